// File: swin_attn.f
+incdir+common
common/swin_attn_data_pkg.sv
common/swin_attn_ctrl_pkg.sv
rtl/query_bias_add.sv
rtl/attn_ctrl.sv
rtl/head_score_mac.sv
rtl/swin_attn_top.sv
testbench/score_checker.sv
testbench/tb_swin_attn.sv

// File: Makefile
TOP = tb_swin_attn

sim:
	verilator --binary --top-module $(TOP) -f swin_attn.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: testbench/tb_swin_attn.sv
`timescale 1ns/10ps
`default_nettype none

`include "swin_attn_defines.svh"

module tb_swin_attn;
  import swin_attn_data_pkg::*;
  import swin_attn_ctrl_pkg::*;

  localparam int MAX_BEATS   = `SA_NUM_HEADS * `SA_MAX_BLOCKS;
  localparam int RAND_TOKENS = 12;
  localparam int EXT_TOKENS  = 4;
  // Worst case beat count, 6 cycles of 8 ns per beat
  localparam int WATCHDOG_NS = (4 + (2 * RAND_TOKENS + EXT_TOKENS + 2) * MAX_BEATS) * 48 + 4000;

  logic       clk;
  logic       rst;
  block_cnt_t block_per_head;
  beat_t      query, key, pos_embed, bias_con, bias_pos;
  logic       in_valid, in_ready;
  score_t     score;
  head_idx_t  score_head;
  logic       score_last, score_valid, score_ready;
  logic       exp_push, exp_last;
  score_t     exp_score;
  head_idx_t  exp_head;
  int         errors, xfers, pending;

  // Fields per beat: query, key, pos_embed, bias_con, bias_pos
  beat_t       tok [MAX_BEATS][5];
  logic [31:0] rng = 32'd85;
  logic [31:0] ready_rng = 32'd85;
  int          ready_mode = 0;
  int          tb_errs = 0;
  int          test_num = 0;
  int          err_mark = 0;

  swin_attn_top dut0 (.*);

  score_checker chk0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  // Own random stream so draws do not depend on process order
  initial begin
    score_ready = 1'b1;
    forever begin
      @(negedge clk);
      ready_rng = xorshift32(ready_rng);
      if (ready_mode == 0) begin
        score_ready = 1'b1;
      end else if (ready_mode == 1) begin
        score_ready = (ready_rng[1:0] != 2'b00);
      end else begin
        score_ready = 1'b0;
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Mode 0 small, 1 range extremes, 2 full range
  function automatic elem_t rand_elem(input int mode);
    rng = xorshift32(rng);
    if (mode == 1) begin
      return {rng[0], {(`SA_DATA_W-1){~rng[0]}}};
    end
    if (mode == 2) begin
      return rng[`SA_DATA_W-1:0];
    end
    return elem_t'($signed(rng[5:0]));
  endfunction

  function automatic longint clamp(input longint v);
    longint lim;
    lim = longint'(1) << (`SA_DATA_W - 1);
    if (v >= lim) begin
      return lim - 1;
    end
    if (v < -lim) begin
      return -lim;
    end
    return v;
  endfunction

  function automatic longint lane_value(input int b, input int f, input int l);
    return longint'(tok[b][f][l]);
  endfunction

  function automatic score_t model_score(input int h, input int bph);
    longint acc;
    acc = 0;
    for (int b = h * bph; b < (h + 1) * bph; b++) begin
      for (int l = 0; l < `SA_PAR; l++) begin
        acc += clamp(lane_value(b, 0, l) + lane_value(b, 3, l)) * lane_value(b, 1, l)
             + clamp(lane_value(b, 0, l) + lane_value(b, 4, l)) * lane_value(b, 2, l);
      end
    end
    return score_t'(clamp(acc >>> `SA_FRAC_W));
  endfunction

  // Mode 3 gives small fixed values
  task automatic fill_token(input int bph, input int mode);
    for (int b = 0; b < bph * `SA_NUM_HEADS; b++) begin
      for (int f = 0; f < 5; f++) begin
        for (int l = 0; l < `SA_PAR; l++) begin
          tok[b][f][l] = (mode == 3) ? elem_t'(b + f - l - 1) : rand_elem(mode);
        end
      end
    end
  endtask

  task automatic push_expected(input int bph);
    for (int h = 0; h < `SA_NUM_HEADS; h++) begin
      exp_score = model_score(h, bph);
      exp_head  = head_idx_t'(h);
      exp_last  = (h == `SA_NUM_HEADS - 1);
      exp_push  = 1'b1;
      @(negedge clk);
    end
    exp_push = 1'b0;
  endtask

  task automatic send_beat(input int b);
    query     = tok[b][0];
    key       = tok[b][1];
    pos_embed = tok[b][2];
    bias_con  = tok[b][3];
    bias_pos  = tok[b][4];
    in_valid  = 1'b1;
    do @(posedge clk); while (!in_ready);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // A partial token is sent without expected scores
  task automatic send_token(input int bph, input int mode, input int beats);
    fill_token(bph, mode);
    if (beats == bph * `SA_NUM_HEADS) begin
      push_expected(bph);
    end
    block_per_head = block_cnt_t'(bph);
    for (int b = 0; b < beats; b++) begin
      send_beat(b);
    end
  endtask

  task automatic send_random_tokens(input int count, input int mode);
    int bph;
    for (int t = 0; t < count; t++) begin
      rng = xorshift32(rng);
      bph = int'(rng[2:0]) + 1;
      send_token(bph, (mode == 0 && t % 3 == 2) ? 2 : mode, bph * `SA_NUM_HEADS);
    end
  endtask

  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("Expected scores never arrived, %0d still pending", pending);
      tb_errs++;
    end
  endtask

  task automatic end_test(input string name);
    wait_drain();
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, errors + tb_errs - err_mark);
    err_mark = errors + tb_errs;
  endtask

  initial begin
    int lat;
    int xfer_mark;
    rst = 1'b1;
    block_per_head = block_cnt_t'(1);
    query = '0;
    key = '0;
    pos_embed = '0;
    bias_con = '0;
    bias_pos = '0;
    in_valid = 1'b0;
    exp_push = 1'b0;
    exp_score = '0;
    exp_head = '0;
    exp_last = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // One beat per head, score two edges after its input transfer
    fill_token(1, 3);
    push_expected(1);
    for (int b = 0; b < `SA_NUM_HEADS; b++) begin
      send_beat(b);
      lat = 1;
      while (!score_valid && lat < 10) begin
        @(negedge clk);
        lat++;
      end
      if (lat != 2) begin
        $display("ERR %0t: head %0d score after %0d cycles, expected 2", $time, b, lat);
        tb_errs++;
      end
    end
    end_test("fixed values, one block per head");

    send_random_tokens(RAND_TOKENS, 0);
    end_test("random tokens and block counts");

    send_random_tokens(EXT_TOKENS, 1);
    end_test("extreme values");

    set_ready_mode(1);
    xfer_mark = xfers;
    send_random_tokens(RAND_TOKENS, 0);
    wait_drain();
    if (xfers - xfer_mark != RAND_TOKENS * `SA_NUM_HEADS) begin
      $display("ERR %0t: %0d score transfers, expected %0d", $time, xfers - xfer_mark,
               RAND_TOKENS * `SA_NUM_HEADS);
      tb_errs++;
    end
    set_ready_mode(0);
    end_test("score back-pressure");

    // Stall with a score held, then reset inside the token
    set_ready_mode(2);
    send_token(2, 0, 3);
    repeat (2) @(negedge clk);
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    if (score_valid) begin
      $display("ERR %0t: score_valid still high after reset", $time);
      tb_errs++;
    end
    set_ready_mode(0);
    send_token(3, 0, 3 * `SA_NUM_HEADS);
    end_test("reset in the middle of a token");

    $display("Tests %0d, score transfers %0d, errors %0d", test_num, xfers, errors + tb_errs);
    if (errors + tb_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/score_checker.sv
`timescale 1ns/10ps
`default_nettype none

module score_checker (
  input  logic                          clk,
  input  logic                          rst,
  input  swin_attn_data_pkg::score_t    score,
  input  swin_attn_ctrl_pkg::head_idx_t score_head,
  input  logic                          score_last,
  input  logic                          score_valid,
  input  logic                          score_ready,
  input  logic                          exp_push,
  input  swin_attn_data_pkg::score_t    exp_score,
  input  swin_attn_ctrl_pkg::head_idx_t exp_head,
  input  logic                          exp_last,
  output int                            errors,
  output int                            xfers,
  output int                            pending
);
  import swin_attn_data_pkg::*;
  import swin_attn_ctrl_pkg::*;

  // Expected items as {last, head, score}
  logic [$bits(score_t)+$bits(head_idx_t):0] exp_q[$];
  score_t    want_score;
  head_idx_t want_head;
  logic      want_last;
  int        err_cnt = 0;
  int        xfer_cnt = 0;
  int        pend_cnt = 0;

  assign errors  = err_cnt;
  assign xfers   = xfer_cnt;
  assign pending = pend_cnt;

  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
    end else begin
      if (exp_push) begin
        exp_q.push_back({exp_last, exp_head, exp_score});
      end
      if (score_valid && score_ready) begin
        xfer_cnt++;
        if (exp_q.size() == 0) begin
          $display("Score transfer at %0t arrived with no score expected", $time);
          err_cnt++;
        end else begin
          {want_last, want_head, want_score} = exp_q.pop_front();
          if (score != want_score || score_head != want_head || score_last != want_last) begin
            $display("ERR %0t: head %0d last %0b score %0d, expected head %0d last %0b score %0d",
                     $time, score_head, score_last, score, want_head, want_last, want_score);
            err_cnt++;
          end
        end
      end
    end
    pend_cnt = exp_q.size();
  end

endmodule

`default_nettype wire

// File: rtl/swin_attn_top.sv
`timescale 1ns/10ps
`default_nettype none

module swin_attn_top (
  input  logic                           clk,
  input  logic                           rst,
  input  swin_attn_ctrl_pkg::block_cnt_t block_per_head,
  input  swin_attn_data_pkg::beat_t      query,
  input  swin_attn_data_pkg::beat_t      key,
  input  swin_attn_data_pkg::beat_t      pos_embed,
  input  swin_attn_data_pkg::beat_t      bias_con,
  input  swin_attn_data_pkg::beat_t      bias_pos,
  input  logic                           in_valid,
  output logic                           in_ready,
  output swin_attn_data_pkg::score_t     score,
  output swin_attn_ctrl_pkg::head_idx_t  score_head,
  output logic                           score_last,
  output logic                           score_valid,
  input  logic                           score_ready
);
  import swin_attn_data_pkg::*;
  import swin_attn_ctrl_pkg::*;

  beat_t     q_con;
  beat_t     q_pos;
  beat_t     key_r;
  beat_t     pos_r;
  logic      beat_valid;
  logic      beat_ready;
  logic      beat_fire;
  logic      acc_first;
  logic      acc_last;
  logic      token_last;
  head_idx_t head_idx;

  assign beat_fire = beat_valid && beat_ready;

  query_bias_add bias_add_i (
    .clk        (clk),
    .rst        (rst),
    .query      (query),
    .key        (key),
    .pos_embed  (pos_embed),
    .bias_con   (bias_con),
    .bias_pos   (bias_pos),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .q_con      (q_con),
    .q_pos      (q_pos),
    .key_out    (key_r),
    .pos_out    (pos_r),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready)
  );

  // Frames beats into heads as they enter the MAC
  attn_ctrl ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .block_per_head (block_per_head),
    .beat_fire      (beat_fire),
    .acc_first      (acc_first),
    .acc_last       (acc_last),
    .token_last     (token_last),
    .head_idx       (head_idx)
  );

  head_score_mac mac_i (
    .clk         (clk),
    .rst         (rst),
    .q_con       (q_con),
    .q_pos       (q_pos),
    .key         (key_r),
    .pos_embed   (pos_r),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .acc_first   (acc_first),
    .acc_last    (acc_last),
    .token_last  (token_last),
    .head_idx    (head_idx),
    .score       (score),
    .score_head  (score_head),
    .score_last  (score_last),
    .score_valid (score_valid),
    .score_ready (score_ready)
  );

endmodule

`default_nettype wire

// File: rtl/head_score_mac.sv
`timescale 1ns/10ps
`default_nettype none

`include "swin_attn_defines.svh"

module head_score_mac (
  input  logic                          clk,
  input  logic                          rst,
  input  swin_attn_data_pkg::beat_t     q_con,
  input  swin_attn_data_pkg::beat_t     q_pos,
  input  swin_attn_data_pkg::beat_t     key,
  input  swin_attn_data_pkg::beat_t     pos_embed,
  input  logic                          beat_valid,
  output logic                          beat_ready,
  input  logic                          acc_first,
  input  logic                          acc_last,
  input  logic                          token_last,
  input  swin_attn_ctrl_pkg::head_idx_t head_idx,
  output swin_attn_data_pkg::score_t    score,
  output swin_attn_ctrl_pkg::head_idx_t score_head,
  output logic                          score_last,
  output logic                          score_valid,
  input  logic                          score_ready
);
  import swin_attn_data_pkg::*;
  import swin_attn_ctrl_pkg::*;

  acc_t   acc;
  acc_t   beat_sum;
  acc_t   acc_next;
  acc_t   scaled;
  score_t score_sat;
  logic   beat_fire;

  // Content and positional products of all lanes
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < `SA_PAR; i++) begin
      beat_sum = beat_sum
               + acc_t'($signed(q_con[i]) * $signed(key[i]))
               + acc_t'($signed(q_pos[i]) * $signed(pos_embed[i]));
    end
  end

  assign acc_next = acc_first ? beat_sum : acc + beat_sum;
  assign scaled   = acc_next >>> `SA_FRAC_W;

  // Fits when all bits above the score sign bit match it
  always_comb begin
    if (&scaled[`SA_ACC_W-1:`SA_DATA_W-1] || ~|scaled[`SA_ACC_W-1:`SA_DATA_W-1]) begin
      score_sat = scaled[`SA_DATA_W-1:0];
    end else if (scaled[`SA_ACC_W-1]) begin
      score_sat = {1'b1, {(`SA_DATA_W-1){1'b0}}};
    end else begin
      score_sat = {1'b0, {(`SA_DATA_W-1){1'b1}}};
    end
  end

  assign beat_ready = !score_valid || score_ready;
  assign beat_fire  = beat_valid && beat_ready;

  always_ff @(posedge clk) begin
    if (beat_fire) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      score_valid <= 1'b0;
    end else if (beat_fire && acc_last) begin
      score_valid <= 1'b1;
    end else if (score_ready) begin
      score_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_fire && acc_last) begin
      score      <= score_sat;
      score_head <= head_idx;
      score_last <= token_last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/attn_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "swin_attn_defines.svh"

module attn_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  swin_attn_ctrl_pkg::block_cnt_t block_per_head,
  input  logic                           beat_fire,
  output logic                           acc_first,
  output logic                           acc_last,
  output logic                           token_last,
  output swin_attn_ctrl_pkg::head_idx_t  head_idx
);
  import swin_attn_ctrl_pkg::*;

  ctrl_state_t state;
  block_cnt_t  blk_cnt;
  block_cnt_t  bph_q;
  block_cnt_t  cur_bph;
  head_idx_t   head_cnt;

  // First beat of a token sees the live config, later beats the sampled one
  assign cur_bph = (state == S_IDLE) ? block_per_head : bph_q;

  assign acc_first  = (blk_cnt == '0);
  assign acc_last   = (blk_cnt == cur_bph - block_cnt_t'(1));
  assign token_last = (head_cnt == head_idx_t'(`SA_NUM_HEADS - 1));
  assign head_idx   = head_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= S_IDLE;
      blk_cnt  <= '0;
      head_cnt <= '0;
      bph_q    <= '0;
    end else if (beat_fire) begin
      if (state == S_IDLE) begin
        bph_q <= block_per_head;
      end
      if (acc_last) begin
        blk_cnt <= '0;
        if (token_last) begin
          // Token done, wait for the next first beat
          head_cnt <= '0;
          state    <= S_IDLE;
        end else begin
          head_cnt <= head_cnt + head_idx_t'(1);
          state    <= S_TOKEN;
        end
      end else begin
        blk_cnt <= blk_cnt + block_cnt_t'(1);
        state   <= S_TOKEN;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/query_bias_add.sv
`timescale 1ns/10ps
`default_nettype none

`include "swin_attn_defines.svh"

module query_bias_add (
  input  logic                      clk,
  input  logic                      rst,
  input  swin_attn_data_pkg::beat_t query,
  input  swin_attn_data_pkg::beat_t key,
  input  swin_attn_data_pkg::beat_t pos_embed,
  input  swin_attn_data_pkg::beat_t bias_con,
  input  swin_attn_data_pkg::beat_t bias_pos,
  input  logic                      in_valid,
  output logic                      in_ready,
  output swin_attn_data_pkg::beat_t q_con,
  output swin_attn_data_pkg::beat_t q_pos,
  output swin_attn_data_pkg::beat_t key_out,
  output swin_attn_data_pkg::beat_t pos_out,
  output logic                      beat_valid,
  input  logic                      beat_ready
);
  import swin_attn_data_pkg::*;

  beat_t con_sum;
  beat_t pos_sum;
  logic  in_fire;

  // Clamp to the elem_t range on overflow
  function automatic elem_t sat_add(input elem_t a, input elem_t b);
    logic signed [`SA_DATA_W:0] sum;
    sum = {a[`SA_DATA_W-1], a} + {b[`SA_DATA_W-1], b};
    if (sum[`SA_DATA_W] != sum[`SA_DATA_W-1]) begin
      sat_add = sum[`SA_DATA_W] ? {1'b1, {(`SA_DATA_W-1){1'b0}}}
                                : {1'b0, {(`SA_DATA_W-1){1'b1}}};
    end else begin
      sat_add = sum[`SA_DATA_W-1:0];
    end
  endfunction

  // Content and positional adders share the query lane
  always_comb begin
    for (int i = 0; i < `SA_PAR; i++) begin
      con_sum[i] = sat_add(query[i], bias_con[i]);
      pos_sum[i] = sat_add(query[i], bias_pos[i]);
    end
  end

  assign in_ready = !beat_valid || beat_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_valid <= 1'b0;
    end else if (in_ready) begin
      beat_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      q_con   <= con_sum;
      q_pos   <= pos_sum;
      key_out <= key;
      pos_out <= pos_embed;
    end
  end

endmodule

`default_nettype wire

// File: common/swin_attn_ctrl_pkg.sv
`default_nettype none

`include "swin_attn_defines.svh"

package swin_attn_ctrl_pkg;

  typedef enum logic {
    S_IDLE,
    S_TOKEN
  } ctrl_state_t;

  typedef logic [$clog2(`SA_NUM_HEADS)-1:0] head_idx_t;

  // Has to hold SA_MAX_BLOCKS itself
  typedef logic [$clog2(`SA_MAX_BLOCKS+1)-1:0] block_cnt_t;

endpackage

`default_nettype wire

// File: common/swin_attn_data_pkg.sv
`default_nettype none

`include "swin_attn_defines.svh"

package swin_attn_data_pkg;

  typedef logic signed [`SA_DATA_W-1:0] elem_t;

  // One beat, lane 0 in the low bits
  typedef elem_t [`SA_PAR-1:0] beat_t;

  typedef logic signed [`SA_ACC_W-1:0] acc_t;

  typedef logic signed [`SA_DATA_W-1:0] score_t;

endpackage

`default_nettype wire

// File: common/swin_attn_defines.svh
`ifndef SWIN_ATTN_DEFINES_SVH
`define SWIN_ATTN_DEFINES_SVH

// Lanes per beat
`define SA_PAR 4

// Fixed-point element format
`define SA_DATA_W 16
`define SA_FRAC_W 3

// Heads per token and largest block_per_head
`define SA_NUM_HEADS 4
`define SA_MAX_BLOCKS 8

// Wide enough for 2 * SA_PAR products over SA_MAX_BLOCKS beats
`define SA_ACC_W 40

`endif
